//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module memAlignTb -f vlog.f -o memAlignSim

simOut=$(./obj_dir/memAlignSim) || true
echo "$simOut"

if echo "$simOut" | grep -qx "Test OK"; then
    exit 0
else
    exit 1
fi

//--- verif/memAlignTb.sv
`timescale 1ns/100ps
`default_nettype none

module memAlignTb
    import memAlignPkg::*;
();

    localparam int NUM_VEC        = 24;
    localparam int SECTION_B      = 12;
    // six setup writes and one refill
    localparam int FILL_CYCLES    = 7;
    localparam int TIMEOUT_CYCLES = NUM_VEC + FILL_CYCLES + 20;

    logic       clk;
    logic       arstN;
    memReq_t    req;
    tlbFill_t   fill;
    alignResp_t resp;

    memReq_t    reqTbl [NUM_VEC];
    alignResp_t expTbl [NUM_VEC];
    // TLB contents for the first and second table sections
    tlbEntry_t [TLB_ENTRIES-1:0] tlbA;
    tlbEntry_t [TLB_ENTRIES-1:0] tlbB;

    integer seed;
    int     cycleCount;

    memAlign i_memAlign (
        .clk   (clk),
        .arstN (arstN),
        .req   (req),
        .fill  (fill),
        .resp  (resp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic tlbEntry_t mkEntry(input logic [19:0] vpn, input logic [2:0] pfn,
                                          input logic p, input logic w, input logic u);
        tlbEntry_t e;
        e = '{valid: 1'b1, vpn: vpn, pfn: pfn, present: p, writable: w, uncached: u};
        return e;
    endfunction

    // 4 KB pages, first valid match in index order
    function automatic tlbResult_t translate(input logic [31:0] va, input logic wr,
                                             input tlbEntry_t [TLB_ENTRIES-1:0] tlb);
        tlbResult_t res;
        logic       found;
        res   = '0;
        found = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!found && tlb[i].valid && tlb[i].vpn == va[31:12]) begin
                found        = 1'b1;
                res.hit      = 1'b1;
                res.pfn      = tlb[i].pfn;
                res.uncached = tlb[i].uncached;
                res.fault    = !tlb[i].present || (wr && !tlb[i].writable);
            end
        end
        return res;
    endfunction

    function automatic alignResp_t modelResp(input memReq_t r,
                                             input tlbEntry_t [TLB_ENTRIES-1:0] tlb);
        alignResp_t e;
        tlbResult_t t0;
        tlbResult_t t1;
        int         off;
        int         cnt;
        int         last;
        e    = '0;
        off  = int'(r.vAddr[3:0]);
        cnt  = 1 << r.sizeCode;
        last = off + cnt - 1;
        e.part0.valid = 1'b1;
        e.part0.vAddr = r.vAddr;
        e.part0.data  = r.data << (8 * off);
        e.part1.valid = (off + cnt > 16);
        e.part1.vAddr = (r.vAddr + 32'd16) & ~32'hF;
        e.part1.data  = r.data >> (8 * (16 - off));
        for (int b = 0; b < 16; b++) begin
            e.part0.byteMask[b] = (b >= off) && (b <= ((last > 15) ? 15 : last));
            e.part1.byteMask[b] = e.part1.valid && (b <= last - 16);
        end
        t0 = translate(r.vAddr, r.write, tlb);
        t1 = translate(e.part1.vAddr, r.write, tlb);
        e.part0.physAddr = {t0.pfn, r.vAddr[11:0]};
        e.part1.physAddr = {t1.pfn, e.part1.vAddr[11:0]};
        e.tlbMiss   = !t0.hit || (e.part1.valid && !t1.hit);
        e.protFault = (t0.hit && t0.fault) || (e.part1.valid && t1.hit && t1.fault);
        e.uncached  = (t0.hit && t0.uncached) || (e.part1.valid && t1.hit && t1.uncached);
        return e;
    endfunction

    // operand in the low bytes, upper bytes zero
    task automatic setStim(input int idx, input logic [31:0] va, input logic [1:0] sz,
                           input logic wr);
        logic [127:0] raw;
        raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
        reqTbl[idx].valid    = 1'b1;
        reqTbl[idx].vAddr    = va;
        reqTbl[idx].sizeCode = sz;
        reqTbl[idx].write    = wr;
        reqTbl[idx].data     = raw & ((128'd1 << (8 << sz)) - 128'd1);
    endtask

    task automatic checkPart(input string name, input linePart_t exp, input linePart_t act);
        if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
            $display("ERROR at %0t: %s expected %h actual %h", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkFlags(input string name, input alignResp_t exp, input alignResp_t act);
        if (exp.tlbMiss !== act.tlbMiss) begin
            $display("ERROR at %0t: %s.tlbMiss expected %b actual %b",
                     $time, name, exp.tlbMiss, act.tlbMiss);
            abortRun();
        end
        if (exp.protFault !== act.protFault) begin
            $display("ERROR at %0t: %s.protFault expected %b actual %b",
                     $time, name, exp.protFault, act.protFault);
            abortRun();
        end
        if (exp.uncached !== act.uncached) begin
            $display("ERROR at %0t: %s.uncached expected %b actual %b",
                     $time, name, exp.uncached, act.uncached);
            abortRun();
        end
    endtask

    task automatic checkResp(input int i);
        checkPart($sformatf("resp.part0 (vector %0d)", i), expTbl[i].part0, resp.part0);
        checkPart($sformatf("resp.part1 (vector %0d)", i), expTbl[i].part1, resp.part1);
        checkFlags($sformatf("resp (vector %0d)", i), expTbl[i], resp);
    endtask

    task automatic writeTlb(input int idx, input tlbEntry_t e);
        @(posedge clk);
        fill <= '{valid: 1'b1, index: 3'(idx), entry: e};
    endtask

    // one request per cycle, each checked two edges after it was driven
    task automatic runSection(input int first, input int last);
        int n;
        n = last - first + 1;
        for (int c = 0; c < n + 2; c++) begin
            @(posedge clk);
            if (c < n) begin
                req <= reqTbl[first + c];
            end else begin
                req <= '0;
            end
            @(negedge clk);
            if (c >= 2) begin
                checkResp(first + c - 2);
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        arstN      = 1'b0;
        req        = '0;
        fill       = '0;
        cycleCount = 0;
        seed       = 32'h77ef_2876;

        tlbA    = '0;
        tlbA[0] = mkEntry(20'h00010, 3'd1, 1'b1, 1'b1, 1'b0);
        tlbA[1] = mkEntry(20'h00011, 3'd2, 1'b1, 1'b1, 1'b0);
        tlbA[2] = mkEntry(20'h00012, 3'd3, 1'b1, 1'b0, 1'b0);
        tlbA[3] = mkEntry(20'h00013, 3'd4, 1'b1, 1'b1, 1'b1);
        tlbA[4] = mkEntry(20'h00020, 3'd5, 1'b0, 1'b1, 1'b0);
        tlbA[5] = mkEntry(20'h00030, 3'd6, 1'b1, 1'b0, 1'b1);
        // page 0x20 becomes present for the second section
        tlbB    = tlbA;
        tlbB[4] = mkEntry(20'h00020, 3'd7, 1'b1, 1'b1, 1'b0);

        // within-line accesses, crossings, page cross, misses, read-only store
        setStim(0, 32'h0001_0000, 2'd0, 1'b0);
        setStim(1, 32'h0001_0005, 2'd0, 1'b1);
        setStim(2, 32'h0001_0002, 2'd1, 1'b0);
        setStim(3, 32'h0001_0004, 2'd2, 1'b1);
        setStim(4, 32'h0001_0008, 2'd3, 1'b0);
        setStim(5, 32'h0002_000E, 2'd1, 1'b1);
        setStim(6, 32'h0001_001D, 2'd3, 1'b0);
        setStim(7, 32'h0001_002F, 2'd1, 1'b1);
        setStim(8, 32'h0001_0FFC, 2'd3, 1'b0);
        setStim(9, 32'h0005_0010, 2'd2, 1'b0);
        setStim(10, 32'h0001_3FFC, 2'd3, 1'b0);
        setStim(11, 32'h0001_2040, 2'd2, 1'b1);
        // after the refill
        setStim(12, 32'h0001_2040, 2'd2, 1'b0);
        setStim(13, 32'h0002_0010, 2'd3, 1'b1);
        setStim(14, 32'h0001_1FFC, 2'd3, 1'b1);
        setStim(15, 32'h0001_2FFF, 2'd1, 1'b0);
        setStim(16, 32'h0003_0007, 2'd0, 1'b0);
        setStim(17, 32'h0003_0007, 2'd0, 1'b1);
        setStim(18, 32'h0002_000F, 2'd3, 1'b0);
        setStim(19, 32'h0001_0003, 2'd3, 1'b1);
        // last line of a page, next page faults, misses or is uncached
        setStim(20, 32'h0001_1FF1, 2'd1, 1'b1);
        setStim(21, 32'h0001_3FF0, 2'd0, 1'b1);
        setStim(22, 32'h0001_2FFC, 2'd2, 1'b0);
        setStim(23, 32'h0001_FFF9, 2'd3, 1'b0);
        for (int i = 0; i < NUM_VEC; i++) begin
            expTbl[i] = modelResp(reqTbl[i], (i < SECTION_B) ? tlbA : tlbB);
        end

        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkPart("resp.part0 after reset", '0, resp.part0);
        checkPart("resp.part1 after reset", '0, resp.part1);
        checkFlags("resp after reset", '0, resp);

        for (int i = 0; i < 6; i++) begin
            writeTlb(i, tlbA[i]);
        end
        @(posedge clk);
        fill <= '0;
        runSection(0, SECTION_B - 1);

        writeTlb(4, tlbB[4]);
        @(posedge clk);
        fill <= '0;
        runSection(SECTION_B, NUM_VEC - 1);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/memAlign_checker.sv
`timescale 1ns/100ps
`default_nettype none

module memAlignChecker
    import memAlignPkg::*;
(
    input logic       clk,
    input logic       arstN,
    input alignResp_t resp
);

    // second line part only exists as the tail of a first part
    part1NeedsPart0: assert property (@(posedge clk) disable iff (!arstN)
        resp.part1.valid |-> resp.part0.valid)
        else $error("part1 valid while part0 is invalid");

    // flags belong to a live response
    flagsNeedPart0: assert property (@(posedge clk) disable iff (!arstN)
        !resp.part0.valid |-> !(resp.tlbMiss || resp.protFault || resp.uncached))
        else $error("response flag set while part0 is invalid");

    // every access touches at least one byte on its first line
    part0MaskNonZero: assert property (@(posedge clk) disable iff (!arstN)
        resp.part0.valid |-> (resp.part0.byteMask != '0))
        else $error("part0 valid with an empty byte mask");

endmodule

bind memAlign memAlignChecker i_memAlignChecker (
    .clk   (clk),
    .arstN (arstN),
    .resp  (resp)
);

`default_nettype wire

//--- verilog/accessSplit.sv
`timescale 1ns/100ps
`default_nettype none

module accessSplit
    import memAlignPkg::*;
(
    input  logic         clk,
    input  logic         arstN,
    input  memReq_t      req,
    output splitAccess_t split
);

    logic [OFFSET_W-1:0] offset;
    logic [OFFSET_W:0]   byteCount;
    logic [OFFSET_W:0]   lineEnd;
    logic                crossing;
    logic [31:0]         nextLine;

    // position of the access inside its line
    assign offset = req.vAddr[OFFSET_W-1:0];

    // 1, 2, 4 or 8 bytes
    assign byteCount = (OFFSET_W + 1)'(1) << req.sizeCode;

    // one past the last byte, relative to the line start
    assign lineEnd = {1'b0, offset} + byteCount;

    assign crossing = lineEnd > (OFFSET_W + 1)'(LINE_BYTES);

    // start of the following line
    assign nextLine = {req.vAddr[31:OFFSET_W] + (32 - OFFSET_W)'(1), {OFFSET_W{1'b0}}};

    // stage 1 register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            split.valid <= 1'b0;
        end else begin
            split.valid <= req.valid;
            // payload only moves with a live request
            if (req.valid) begin
                split.write     <= req.write;
                split.vAddr0    <= req.vAddr;
                split.vAddr1    <= nextLine;
                split.offset    <= offset;
                split.byteCount <= byteCount;
                split.crossing  <= crossing;
                split.data      <= req.data;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/alignOut.sv
`timescale 1ns/100ps
`default_nettype none

module alignOut
    import memAlignPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  linePart_t  lane0,
    input  linePart_t  lane1,
    input  tlbResult_t tlb0,
    input  tlbResult_t tlb1,
    output alignResp_t resp
);

    alignResp_t respNext;

    always_comb begin
        respNext.part0 = lane0;
        respNext.part1 = lane1;

        // frame number on top of the page offset
        respNext.part0.physAddr = {tlb0.pfn, lane0.vAddr[PAGE_OFF_W-1:0]};
        respNext.part1.physAddr = {tlb1.pfn, lane1.vAddr[PAGE_OFF_W-1:0]};

        // flags only count for parts that exist
        respNext.tlbMiss   = (lane0.valid && !tlb0.hit) ||
                             (lane1.valid && !tlb1.hit);
        respNext.protFault = (lane0.valid && tlb0.hit && tlb0.fault) ||
                             (lane1.valid && tlb1.hit && tlb1.fault);
        respNext.uncached  = (lane0.valid && tlb0.hit && tlb0.uncached) ||
                             (lane1.valid && tlb1.hit && tlb1.uncached);
    end

    // stage 2 register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resp.part0.valid <= 1'b0;
            resp.part1.valid <= 1'b0;
            resp.tlbMiss     <= 1'b0;
            resp.protFault   <= 1'b0;
            resp.uncached    <= 1'b0;
        end else begin
            resp <= respNext;
        end
    end

endmodule

`default_nettype wire

//--- verilog/laneAlign.sv
`timescale 1ns/100ps
`default_nettype none

module laneAlign
    import memAlignPkg::*;
(
    input  splitAccess_t split,
    output linePart_t    lane0,
    output linePart_t    lane1
);

    logic [OFFSET_W:0]   endByte;
    logic [OFFSET_W:0]   downBytes;
    logic [OFFSET_W+3:0] upShift;
    logic [OFFSET_W+3:0] downShift;

    // last byte touched, may run past the line
    assign endByte = {1'b0, split.offset} + split.byteCount - (OFFSET_W + 1)'(1);

    // part 1 lanes start where part 0 ran out
    assign downBytes = (OFFSET_W + 1)'(LINE_BYTES) - {1'b0, split.offset};

    // byte counts to bit counts
    assign upShift   = {1'b0, split.offset, 3'b000};
    assign downShift = {downBytes, 3'b000};

    always_comb begin
        lane0.valid    = split.valid;
        lane0.vAddr    = split.vAddr0;
        lane0.physAddr = '0;
        lane0.data     = split.data << upShift;

        lane1.valid    = split.valid && split.crossing;
        lane1.vAddr    = split.vAddr1;
        lane1.physAddr = '0;
        // zero fill from the top
        lane1.data     = split.data >> downShift;

        for (int b = 0; b < LINE_BYTES; b++) begin
            // end past byte 15 clips itself here
            lane0.byteMask[b] = (b >= split.offset) && (b <= endByte);
            // spill bytes on the next line
            lane1.byteMask[b] = split.crossing && (b + LINE_BYTES <= endByte);
        end
    end

endmodule

`default_nettype wire

//--- verilog/memAlign.sv
`timescale 1ns/100ps
`default_nettype none

module memAlign
    import memAlignPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  memReq_t    req,
    input  tlbFill_t   fill,
    output alignResp_t resp
);

    splitAccess_t split;
    tlbResult_t   tlb0;
    tlbResult_t   tlb1;
    linePart_t    lane0;
    linePart_t    lane1;

    accessSplit i_accessSplit (
        .clk   (clk),
        .arstN (arstN),
        .req   (req),
        .split (split)
    );

    // both line parts translate in the same cycle
    tlbLookup i_tlbLookup (
        .clk    (clk),
        .arstN  (arstN),
        .fill   (fill),
        .write  (split.write),
        .vAddr0 (split.vAddr0),
        .vAddr1 (split.vAddr1),
        .tlb0   (tlb0),
        .tlb1   (tlb1)
    );

    laneAlign i_laneAlign (
        .split (split),
        .lane0 (lane0),
        .lane1 (lane1)
    );

    alignOut i_alignOut (
        .clk   (clk),
        .arstN (arstN),
        .lane0 (lane0),
        .lane1 (lane1),
        .tlb0  (tlb0),
        .tlb1  (tlb1),
        .resp  (resp)
    );

endmodule

`default_nettype wire

//--- verilog/memAlignPkg.sv
`default_nettype none

package memAlignPkg;

    // line and translation geometry
    localparam int LINE_BYTES  = 16;
    localparam int OFFSET_W    = $clog2(LINE_BYTES);
    localparam int TLB_ENTRIES = 8;
    localparam int VPN_W       = 20;
    localparam int PFN_W       = 3;
    localparam int PADDR_W     = 15;
    // 4 KB pages
    localparam int PAGE_OFF_W  = 32 - VPN_W;

    typedef struct packed {
        logic                    valid;
        logic [31:0]             vAddr;
        logic [1:0]              sizeCode;
        logic                    write;
        logic [LINE_BYTES*8-1:0] data;
    } memReq_t;

    typedef struct packed {
        logic             valid;
        logic [VPN_W-1:0] vpn;
        logic [PFN_W-1:0] pfn;
        logic             present;
        logic             writable;
        logic             uncached;
    } tlbEntry_t;

    typedef struct packed {
        logic                           valid;
        logic [$clog2(TLB_ENTRIES)-1:0] index;
        tlbEntry_t                      entry;
    } tlbFill_t;

    typedef struct packed {
        logic             hit;
        logic             fault;
        logic             uncached;
        logic [PFN_W-1:0] pfn;
    } tlbResult_t;

    // request after the first stage
    typedef struct packed {
        logic                    valid;
        logic                    write;
        logic [31:0]             vAddr0;
        logic [31:0]             vAddr1;
        logic [OFFSET_W-1:0]     offset;
        logic [OFFSET_W:0]       byteCount;
        logic                    crossing;
        logic [LINE_BYTES*8-1:0] data;
    } splitAccess_t;

    typedef struct packed {
        logic                    valid;
        logic [31:0]             vAddr;
        logic [PADDR_W-1:0]      physAddr;
        logic [LINE_BYTES-1:0]   byteMask;
        logic [LINE_BYTES*8-1:0] data;
    } linePart_t;

    typedef struct packed {
        linePart_t part0;
        linePart_t part1;
        logic      tlbMiss;
        logic      protFault;
        logic      uncached;
    } alignResp_t;

endpackage

`default_nettype wire

//--- verilog/tlbLookup.sv
`timescale 1ns/100ps
`default_nettype none

module tlbLookup
    import memAlignPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  tlbFill_t    fill,
    input  logic        write,
    input  logic [31:0] vAddr0,
    input  logic [31:0] vAddr1,
    output tlbResult_t  tlb0,
    output tlbResult_t  tlb1
);

    tlbEntry_t entries [TLB_ENTRIES];

    // fill port, all entries invalid out of reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (fill.valid) begin
            entries[fill.index] <= fill.entry;
        end
    end

    // fully associative match, lowest index wins
    function automatic tlbResult_t lookup(
        input logic [31:0] vAddr,
        input logic        isWrite
    );
        tlbResult_t res;
        res = '0;
        // walk downward so the lowest matching entry is written last
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].vpn == vAddr[31 -: VPN_W]) begin
                res.hit      = 1'b1;
                res.pfn      = entries[i].pfn;
                res.uncached = entries[i].uncached;
                // not present, or a store to a read-only page
                res.fault    = !entries[i].present ||
                               (isWrite && !entries[i].writable);
            end
        end
        return res;
    endfunction

    // two independent read ports into the same array
    always_comb begin
        tlb0 = lookup(vAddr0, write);
        tlb1 = lookup(vAddr1, write);
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/memAlignPkg.sv
verilog/accessSplit.sv
verilog/tlbLookup.sv
verilog/laneAlign.sv
verilog/alignOut.sv
verilog/memAlign.sv
verif/memAlign_checker.sv
verif/memAlignTb.sv
